// File: hw/gamePkg.sv
`default_nettype none

package gamePkg;

	// lanes, slots and the note sequence
	localparam int numLanes = 4;
	localparam int numSlots = 8;
	localparam int seqLength = 32;

	typedef logic [4:0] seqAddr_t;
	typedef logic [2:0] seqCode_t; // 0 none, 1..4 lane 0..3, 5..7 none
	typedef logic [1:0] laneIndex_t;
	typedef logic [2:0] slotIndex_t;

	// screen is 160x120
	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;

	localparam int trackLength = 120; // frame steps from spawn to bottom
	localparam yCoord_t hitWindowStart = 7'd104;
	localparam int laneSpacing = 32;
	localparam int laneOffset = 16;

	typedef logic [2:0] colour_t; // {r, g, b}

	// lane 0 red, 1 yellow, 2 blue, 3 magenta
	localparam colour_t [numLanes-1:0] laneColour = {3'b101, 3'b001, 3'b110, 3'b100};
	localparam colour_t hitColour = 3'b010;
	localparam colour_t missColour = 3'b111;

	typedef enum logic [1:0] {
		slotIdle,
		slotFalling,
		slotHit,
		slotMissed
	} slotState_t;

	typedef logic [15:0] count_t; // wraps

endpackage

`default_nettype wire

// File: hw/inputStage.sv
`timescale 1ns/1ps
`default_nettype none

module inputStage #(
	parameter int frameDivide = 781250,  // 64 Hz at 50 MHz
	parameter int beatDivide = 12500000  // 4 Hz at 50 MHz
) (
	input  logic                         CLOCK_50,
	input  logic                         reset,
	input  logic [gamePkg::numLanes-1:0] keys,
	output logic [gamePkg::numLanes-1:0] keyPress,
	output logic                         frameTick,
	output logic                         beatTick
);
	import gamePkg::*;

	localparam int frameBits = $clog2(frameDivide);
	localparam int beatBits = $clog2(beatDivide);

	logic [frameBits-1:0] frameCount;
	logic [beatBits-1:0] beatCount;
	logic [numLanes-1:0] keySync1;
	logic [numLanes-1:0] keySync2;
	logic [numLanes-1:0] keyLast;

	// free running dividers, tick on the wrap
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			frameCount <= '0;
			beatCount <= '0;
			frameTick <= 1'b0;
			beatTick <= 1'b0;
		end else begin
			frameTick <= (frameCount == frameBits'(frameDivide - 1));
			beatTick <= (beatCount == beatBits'(beatDivide - 1));
			if (frameCount == frameBits'(frameDivide - 1))
				frameCount <= '0;
			else
				frameCount <= frameCount + 1'b1;
			if (beatCount == beatBits'(beatDivide - 1))
				beatCount <= '0;
			else
				beatCount <= beatCount + 1'b1;
		end
	end

	// two flop sync, then rising edge only
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			keySync1 <= '0;
			keySync2 <= '0;
			keyLast <= '0;
			keyPress <= '0;
		end else begin
			keySync1 <= keys;
			keySync2 <= keySync1;
			keyLast <= keySync2;
			keyPress <= keySync2 & ~keyLast; // held key gives one pulse
		end
	end

endmodule

`default_nettype wire

// File: hw/noteSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module noteSequencer (
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic                beatTick,
	input  gamePkg::slotState_t slotState [gamePkg::numSlots],
	output logic                spawnValid,
	output gamePkg::slotIndex_t spawnSlot,
	output gamePkg::laneIndex_t spawnLane,
	output gamePkg::seqCode_t   currentCode
);
	import gamePkg::*;

	seqCode_t noteRom [seqLength];

	seqAddr_t seqAddr;
	logic codeFresh;  // currentCode was loaded on the last beat
	logic codeIsLane;
	laneIndex_t codeLane;
	logic anyIdle;
	slotIndex_t freeSlot;

	initial begin
		$readmemh("hw/noteSequence.mem", noteRom);
	end

	// one rom step per beat
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			seqAddr <= '0;
			currentCode <= '0;
			codeFresh <= 1'b0;
		end else begin
			codeFresh <= beatTick;
			if (beatTick) begin
				currentCode <= noteRom[seqAddr];
				if (seqAddr == seqAddr_t'(seqLength - 1))
					seqAddr <= '0;
				else
					seqAddr <= seqAddr + 1'b1;
			end
		end
	end

	// codes 1..4 name a lane
	assign codeIsLane = (currentCode != '0) && (currentCode <= seqCode_t'(numLanes));
	assign codeLane = laneIndex_t'(currentCode - 1'b1);

	// lowest idle slot wins
	always_comb begin
		anyIdle = 1'b0;
		freeSlot = '0;
		for (int i = numSlots - 1; i >= 0; i--) begin
			if (slotState[i] == slotIdle) begin
				anyIdle = 1'b1;
				freeSlot = slotIndex_t'(i);
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			spawnValid <= 1'b0;
		end else begin
			spawnValid <= codeFresh && codeIsLane && anyIdle; // pool full drops the note
		end
	end

	always_ff @(posedge CLOCK_50) begin
		spawnSlot <= freeSlot;
		spawnLane <= codeLane;
	end

endmodule

`default_nettype wire

// File: hw/noteSlotPool.sv
`timescale 1ns/1ps
`default_nettype none

module noteSlotPool (
	input  logic                         CLOCK_50,
	input  logic                         reset,
	input  logic                         frameTick,
	input  logic [gamePkg::numLanes-1:0] keyPress,
	input  logic                         spawnValid,
	input  gamePkg::slotIndex_t          spawnSlot,
	input  gamePkg::laneIndex_t          spawnLane,
	output gamePkg::laneIndex_t          slotLane [gamePkg::numSlots],
	output gamePkg::yCoord_t             slotPos [gamePkg::numSlots],
	output gamePkg::slotState_t          slotState [gamePkg::numSlots],
	output gamePkg::count_t              score,
	output gamePkg::count_t              misses
);
	import gamePkg::*;

	localparam yCoord_t bottomPos = yCoord_t'(trackLength - 1);

	logic [numSlots-1:0] hitMask;
	logic [numSlots-1:0] missMask;
	logic [numSlots-1:0] advanceMask;
	logic [numSlots-1:0] spawnMask;
	logic [$clog2(numLanes+1)-1:0] hitCount;
	logic [$clog2(numSlots+1)-1:0] missCount;

	// each press takes the lowest falling note of its lane in the window
	always_comb begin
		logic laneFound;
		hitMask = '0;
		for (int l = 0; l < numLanes; l++) begin
			laneFound = 1'b0;
			for (int i = 0; i < numSlots; i++) begin
				if (keyPress[l] && !laneFound
						&& slotState[i] == slotFalling
						&& slotLane[i] == laneIndex_t'(l)
						&& slotPos[i] >= hitWindowStart) begin
					hitMask[i] = 1'b1;
					laneFound = 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < numSlots; i++) begin
			spawnMask[i] = spawnValid && (spawnSlot == slotIndex_t'(i));
			// a hit beats a miss on the same edge
			missMask[i] = frameTick && !hitMask[i] && slotState[i] == slotFalling
				&& slotPos[i] == bottomPos;
			advanceMask[i] = frameTick && !hitMask[i] && slotState[i] == slotFalling
				&& slotPos[i] != bottomPos;
		end
	end

	always_comb begin
		hitCount = '0;
		missCount = '0;
		for (int i = 0; i < numSlots; i++) begin
			hitCount = hitCount + hitMask[i];
			missCount = missCount + missMask[i];
		end
	end

	// slot state machines
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			for (int i = 0; i < numSlots; i++) begin
				slotState[i] <= slotIdle;
			end
			score <= '0;
			misses <= '0;
		end else begin
			for (int i = 0; i < numSlots; i++) begin
				if (spawnMask[i])
					slotState[i] <= slotFalling;
				else if (hitMask[i])
					slotState[i] <= slotHit;
				else if (missMask[i])
					slotState[i] <= slotMissed;
				else if (frameTick && (slotState[i] == slotHit || slotState[i] == slotMissed))
					slotState[i] <= slotIdle; // shown for one frame, then freed
			end
			score <= score + count_t'(hitCount);
			misses <= misses + count_t'(missCount);
		end
	end

	// lane and fall position
	always_ff @(posedge CLOCK_50) begin
		for (int i = 0; i < numSlots; i++) begin
			if (spawnMask[i]) begin
				slotLane[i] <= spawnLane;
				slotPos[i] <= '0;
			end else if (advanceMask[i]) begin
				slotPos[i] <= slotPos[i] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/pixelWriter.sv
`timescale 1ns/1ps
`default_nettype none

module pixelWriter (
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic                frameTick,
	input  gamePkg::laneIndex_t slotLane [gamePkg::numSlots],
	input  gamePkg::yCoord_t    slotPos [gamePkg::numSlots],
	input  gamePkg::slotState_t slotState [gamePkg::numSlots],
	input  logic                pixelReady,
	output logic                pixelValid,
	output logic                pixelLast,
	output gamePkg::xCoord_t    pixelX,
	output gamePkg::yCoord_t    pixelY,
	output gamePkg::colour_t    pixelColour
);
	import gamePkg::*;

	logic frameSeen;    // cycle after frameTick, slots already advanced
	logic startScan;
	logic canLoad;
	logic [numSlots-1:0] liveMask;
	logic [numSlots-1:0] pendingMask;  // slots still to send in this scan
	logic [numSlots-1:0] workMask;
	logic [numSlots-1:0] restMask;
	slotIndex_t scanPtr;
	colour_t recordColour;

	always_comb begin
		for (int i = 0; i < numSlots; i++) begin
			liveMask[i] = (slotState[i] != slotIdle);
		end
	end

	// tick during a running scan is dropped
	assign startScan = frameSeen && (pendingMask == '0);
	assign workMask = startScan ? liveMask : pendingMask;
	assign canLoad = !pixelValid || pixelReady;

	// next active slot, idle ones cost nothing
	always_comb begin
		scanPtr = '0;
		for (int i = numSlots - 1; i >= 0; i--) begin
			if (workMask[i])
				scanPtr = slotIndex_t'(i);
		end
		restMask = workMask;
		restMask[scanPtr] = 1'b0;
	end

	always_comb begin
		case (slotState[scanPtr])
			slotHit:    recordColour = hitColour;
			slotMissed: recordColour = missColour;
			default:    recordColour = laneColour[slotLane[scanPtr]];
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			frameSeen <= 1'b0;
			pendingMask <= '0;
			pixelValid <= 1'b0;
			pixelLast <= 1'b0;
		end else begin
			frameSeen <= frameTick;
			if (startScan)
				pendingMask <= liveMask;
			if (canLoad) begin
				pixelValid <= |workMask;
				if (|workMask) begin
					pixelLast <= (restMask == '0);
					pendingMask <= restMask;
				end
			end
		end
	end

	// record fields, held while stalled
	always_ff @(posedge CLOCK_50) begin
		if (canLoad && |workMask) begin
			pixelX <= xCoord_t'(int'(slotLane[scanPtr]) * laneSpacing + laneOffset);
			pixelY <= slotPos[scanPtr];
			pixelColour <= recordColour;
		end
	end

endmodule

`default_nettype wire

// File: hw/rhythmCore.sv
`timescale 1ns/1ps
`default_nettype none

module rhythmCore #(
	parameter int frameDivide = 781250,
	parameter int beatDivide = 12500000
) (
	input  logic                         CLOCK_50,
	input  logic                         reset,
	input  logic [gamePkg::numLanes-1:0] keys,
	input  logic                         pixelReady,
	output logic                         pixelValid,
	output gamePkg::xCoord_t             pixelX,
	output gamePkg::yCoord_t             pixelY,
	output gamePkg::colour_t             pixelColour,
	output logic                         pixelLast,
	output gamePkg::count_t              score,
	output gamePkg::count_t              misses,
	output gamePkg::seqCode_t            currentCode  // board LEDs
);
	import gamePkg::*;

	logic [numLanes-1:0] keyPress;
	logic frameTick;
	logic beatTick;
	logic spawnValid;
	slotIndex_t spawnSlot;
	laneIndex_t spawnLane;
	laneIndex_t slotLane [numSlots];
	yCoord_t slotPos [numSlots];
	slotState_t slotState [numSlots];

	inputStage #(
		.frameDivide(frameDivide),
		.beatDivide(beatDivide)
	) inputs (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.keys(keys),
		.keyPress(keyPress),
		.frameTick(frameTick),
		.beatTick(beatTick)
	);

	noteSequencer sequencer (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.beatTick(beatTick),
		.slotState(slotState),
		.spawnValid(spawnValid),
		.spawnSlot(spawnSlot),
		.spawnLane(spawnLane),
		.currentCode(currentCode)
	);

	noteSlotPool pool (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.frameTick(frameTick),
		.keyPress(keyPress),
		.spawnValid(spawnValid),
		.spawnSlot(spawnSlot),
		.spawnLane(spawnLane),
		.slotLane(slotLane),
		.slotPos(slotPos),
		.slotState(slotState),
		.score(score),
		.misses(misses)
	);

	pixelWriter writer (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.frameTick(frameTick),
		.slotLane(slotLane),
		.slotPos(slotPos),
		.slotState(slotState),
		.pixelReady(pixelReady),
		.pixelValid(pixelValid),
		.pixelLast(pixelLast),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour)
	);

endmodule

`default_nettype wire

// File: bench/rhythmCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rhythmCore_tb;
	import gamePkg::*;

	localparam int frameDiv = 16;
	localparam int beatDiv = 256;
	localparam int bottomY = 119;
	localparam int windowY = 104;
	localparam colour_t hitGreen = 3'b010;
	localparam colour_t missWhite = 3'b111;

	logic CLOCK_50;
	logic reset;
	logic [numLanes-1:0] keys;
	logic pixelReady;
	logic pixelValid;
	xCoord_t pixelX;
	yCoord_t pixelY;
	colour_t pixelColour;
	logic pixelLast;
	count_t score;
	count_t misses;
	seqCode_t currentCode;

	logic [2:0] seqMem [32];  // own copy of the note ROM
	integer seed;
	int mismatchCount;
	int failCount;
	int edgeCount;  // edges since reset release
	int readyMode;  // 0 random, 1 high, 2 low

	// record that transfers on the coming edge
	logic recTaken;
	xCoord_t recX;
	yCoord_t recY;
	colour_t recColour;
	logic recLast;
	int recLoad;  // edge on which that record was loaded

	logic prevValid;
	logic afterLast;  // last transferred record closed a scan
	int lastEndLoad;

	xCoord_t scanX [numSlots];
	yCoord_t scanY [numSlots];
	colour_t scanColour [numSlots];
	int scanCount;

	rhythmCore #(
		.frameDivide(frameDiv),
		.beatDivide(beatDiv)
	) dut (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.keys(keys),
		.pixelReady(pixelReady),
		.pixelValid(pixelValid),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.pixelLast(pixelLast),
		.score(score),
		.misses(misses),
		.currentCode(currentCode)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	function automatic xCoord_t laneX(input int lane);
		return xCoord_t'(lane * 32 + 16);
	endfunction

	function automatic colour_t colourOfLane(input int lane);
		case (lane)
			0: return 3'b100; // red
			1: return 3'b110; // yellow
			2: return 3'b001; // blue
			default: return 3'b101; // magenta
		endcase
	endfunction

	task automatic checkValue(input string signalName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, signalName,
				expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		failCount++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	// one clock, then drive ready and note what will transfer
	task automatic nextCycle();
		logic wasReset;
		logic [31:0] randWord;
		wasReset = reset;
		@(posedge CLOCK_50);
		#1;
		if (!wasReset)
			edgeCount++;
		if (pixelValid && (!prevValid || recTaken))
			recLoad = edgeCount; // new record came in on this edge
		prevValid = pixelValid;
		case (readyMode)
			1: pixelReady = 1'b1;
			2: pixelReady = 1'b0;
			default: begin
				randWord = $random(seed);
				pixelReady = randWord[0];
			end
		endcase
		recTaken = pixelValid && pixelReady;
		recX = pixelX;
		recY = pixelY;
		recColour = pixelColour;
		recLast = pixelLast;
		// a new scan loads no earlier than two edges after a frame tick
		if (recTaken) begin
			if (afterLast && (recLoad - 2) / frameDiv <= (lastEndLoad - 2) / frameDiv)
				reportFailure("pixel record loaded after pixelLast before the next frame tick");
			afterLast = recLast;
			lastEndLoad = recLoad;
		end
	endtask

	// gathers records up to pixelLast
	task automatic collectScan();
		int limit;
		logic done;
		done = 1'b0;
		scanCount = 0;
		limit = 0;
		while (!done && limit < 200) begin
			nextCycle();
			limit++;
			if (recTaken) begin
				for (int j = 0; j < scanCount; j++) begin
					if (scanX[j] == recX && scanY[j] == recY && scanColour[j] == recColour)
						reportFailure("pixel record repeated within one scan");
				end
				if (scanCount == numSlots) begin
					reportFailure("scan ran past the slot count without pixelLast");
					done = 1'b1;
				end else begin
					scanX[scanCount] = recX;
					scanY[scanCount] = recY;
					scanColour[scanCount] = recColour;
					scanCount++;
					done = recLast;
				end
			end
		end
		if (!done)
			reportFailure("timeout waiting for the end of a pixel scan");
	endtask

	task automatic checkQuietOutputs();
		checkValue("pixelValid", 0, pixelValid);
		checkValue("pixelLast", 0, pixelLast);
		checkValue("score", 0, score);
		checkValue("misses", 0, misses);
		checkValue("currentCode", 0, currentCode);
	endtask

	task automatic testResetState();
		reset = 1'b1;
		repeat (2) begin
			nextCycle();
			checkQuietOutputs();
		end
		reset = 1'b0;
		edgeCount = 0;
		nextCycle();
		checkQuietOutputs();
	endtask

	task automatic testSequenceAndSpawn();
		int beat;
		int limit;
		int firstLane;
		int prevY;
		logic seenFirst;
		beat = 1;
		limit = 0;
		prevY = 0;
		seenFirst = 1'b0;
		readyMode = 0;
		firstLane = int'(seqMem[0]) - 1; // entry 0 holds a lane
		if (firstLane < 0 || firstLane >= numLanes)
			reportFailure("entry 0 of the note sequence names no lane");
		while (beat <= 5 && limit < 2000) begin
			nextCycle();
			limit++;
			// sampled mid beat since the code loads one edge after each beat tick
			if (edgeCount == beat * beatDiv + beatDiv / 2) begin
				checkValue("currentCode", seqMem[beat - 1], currentCode);
				beat++;
			end
			if (recTaken && !seenFirst) begin
				seenFirst = 1'b1;
				checkValue("pixelX", laneX(firstLane), recX);
				checkValue("pixelColour", colourOfLane(firstLane), recColour);
				if (recY > 2)
					reportFailure("first record of the spawned note is far below the top");
				prevY = recY;
			end else if (recTaken && recX == laneX(firstLane)
					&& recColour == colourOfLane(firstLane)) begin
				if (recY < prevY)
					reportFailure("fall position of the first note went backwards");
				prevY = recY;
			end
		end
		if (beat <= 5)
			reportFailure("timeout waiting for the first beats");
		if (!seenFirst)
			reportFailure("no pixel record after the first spawn");
	endtask

	task automatic testMiss();
		int limit;
		logic sawMiss;
		readyMode = 1;
		keys = '0;
		sawMiss = 1'b0;
		limit = 0;
		while (!(sawMiss && misses != 0) && limit < 4000) begin
			nextCycle();
			limit++;
			if (recTaken && recColour == missWhite) begin
				sawMiss = 1'b1;
				checkValue("pixelY", bottomY, recY);
			end
		end
		if (!(sawMiss && misses != 0))
			reportFailure("timeout waiting for a missed note");
		checkValue("misses", 1, misses);
		checkValue("score", 0, score);
	endtask

	task automatic testHit();
		int limit;
		int hitLane;
		int freeLane;
		logic found;
		logic sawGreen;
		logic [numLanes-1:0] busyLanes;
		count_t scoreBefore;
		readyMode = 1;
		found = 1'b0;
		hitLane = 0;
		limit = 0;
		while (!found && limit < 3000) begin
			nextCycle();
			limit++;
			for (int l = 0; l < numLanes; l++) begin
				if (recTaken && !found && recX == laneX(l) && recColour == colourOfLane(l)
						&& recY >= windowY && recY <= bottomY - 4) begin
					found = 1'b1;
					hitLane = l;
				end
			end
		end
		if (!found) begin
			reportFailure("timeout waiting for a note inside the hit window");
			return;
		end
		// line the press up so the hit lands on a frame tick, ahead of the scan
		limit = 0;
		while (edgeCount % frameDiv != frameDiv - 3 && limit <= frameDiv) begin
			nextCycle();
			limit++;
		end
		scoreBefore = score;
		keys[hitLane] = 1'b1;
		limit = 0;
		while (score == scoreBefore && limit < 4 + frameDiv) begin
			nextCycle();
			limit++;
		end
		keys = '0;
		checkValue("score", scoreBefore + 1, score);
		sawGreen = 1'b0;
		limit = 0;
		while (!sawGreen && limit < 3 * frameDiv) begin
			nextCycle();
			limit++;
			if (recTaken && recX == laneX(hitLane) && recColour == hitGreen)
				sawGreen = 1'b1;
		end
		if (!sawGreen)
			reportFailure("no hit coloured record for the pressed lane");

		// lanes with a falling note near the window are off limits
		collectScan();
		collectScan();
		busyLanes = '0;
		for (int j = 0; j < scanCount; j++) begin
			for (int l = 0; l < numLanes; l++) begin
				if (scanX[j] == laneX(l) && scanColour[j] == colourOfLane(l)
						&& scanY[j] >= windowY - 8)
					busyLanes[l] = 1'b1;
			end
		end
		freeLane = -1;
		for (int l = numLanes - 1; l >= 0; l--) begin
			if (!busyLanes[l])
				freeLane = l;
		end
		if (freeLane < 0) begin
			reportFailure("every lane has a note near the hit window");
			return;
		end
		scoreBefore = score;
		keys[freeLane] = 1'b1;
		repeat (8) nextCycle();
		keys = '0;
		checkValue("score", scoreBefore, score);
	endtask

	task automatic testBackPressure();
		int limit;
		xCoord_t heldX;
		yCoord_t heldY;
		colour_t heldColour;
		logic heldLast;
		readyMode = 2;
		limit = 0;
		nextCycle();
		while (!pixelValid && limit < 200) begin
			nextCycle();
			limit++;
		end
		if (!pixelValid) begin
			reportFailure("timeout waiting for pixelValid");
			readyMode = 0;
			return;
		end
		heldX = pixelX;
		heldY = pixelY;
		heldColour = pixelColour;
		heldLast = pixelLast;
		repeat (20) begin
			nextCycle();
			checkValue("pixelValid", 1, pixelValid);
			checkValue("pixelX", heldX, pixelX);
			checkValue("pixelY", heldY, pixelY);
			checkValue("pixelColour", heldColour, pixelColour);
			checkValue("pixelLast", heldLast, pixelLast);
		end
		readyMode = 0;
		collectScan(); // tail of the stalled scan
		if (scanCount > 0) begin
			checkValue("pixelX", heldX, scanX[0]);
			checkValue("pixelY", heldY, scanY[0]);
			checkValue("pixelColour", heldColour, scanColour[0]);
		end
		repeat (4) collectScan();
	endtask

	initial begin
		seed = 32'hab6ff7e8;
		mismatchCount = 0;
		failCount = 0;
		edgeCount = 0;
		readyMode = 0;
		recTaken = 1'b0;
		recLoad = 0;
		prevValid = 1'b0;
		afterLast = 1'b0;
		lastEndLoad = 0;
		reset = 1'b1;
		keys = '0;
		pixelReady = 1'b0;
		$readmemh("hw/noteSequence.mem", seqMem);
		testResetState();
		testSequenceAndSpawn();
		testMiss();
		testHit();
		testBackPressure();
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/noteSequence.mem
// one lane code per line, hex: 0 no note, 1..4 lane 0..3, 5..7 no note
// line n is the entry played on beat n+1
1
0
2
0
3
4
0
1
2
0
3
5
1
0
2
3
0
1
0
2
4
0
3
1
0
7
2
0
1
3
0
2

// File: vlog.f
hw/gamePkg.sv
hw/inputStage.sv
hw/noteSequencer.sv
hw/noteSlotPool.sv
hw/pixelWriter.sv
hw/rhythmCore.sv
bench/rhythmCore_tb.sv

// File: Bender.yml
package:
  name: rhythmCore

sources:
  - files:
      - hw/gamePkg.sv
      - hw/inputStage.sv
      - hw/noteSequencer.sv
      - hw/noteSlotPool.sv
      - hw/pixelWriter.sv
      - hw/rhythmCore.sv
  - target: test
    files:
      - bench/rhythmCore_tb.sv
